// File: conv_tiling_pkg.sv
`default_nettype none

package conv_tiling_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // field widths
    ////////////////////////////////////////////////////////////////////////////

    // sizes and origins
    localparam int DIM_W = 16;
    // kernel, stride, padding
    localparam int KER_W = 4;

    // layer configuration, sampled on start
    typedef struct packed {
        logic [DIM_W-1:0] ix;
        logic [DIM_W-1:0] iy;
        logic [DIM_W-1:0] ox;
        logic [DIM_W-1:0] oy;
        logic [KER_W-1:0] k;
        logic [KER_W-1:0] s;
        logic [KER_W-1:0] p;
    } conv_cfg_t;

    // one output tile: origin plus clipped size
    typedef struct packed {
        logic [DIM_W-1:0] ox_start;
        logic [DIM_W-1:0] oy_start;
        logic [DIM_W-1:0] pox;
        logic [DIM_W-1:0] poy;
    } tile_desc_t;

    // input window of a tile, origin may sit left of / above the map
    typedef struct packed {
        logic signed [DIM_W:0] ix_start;
        logic signed [DIM_W:0] iy_start;
        logic [DIM_W-1:0]      iw;
        logic [DIM_W-1:0]      ih;
        logic [KER_W+3:0]      pad_l;
        logic [KER_W+3:0]      pad_r;
        logic [KER_W+3:0]      pad_t;
        logic [KER_W+3:0]      pad_b;
    } win_desc_t;

    // descriptor handed to the consumer
    typedef struct packed {
        tile_desc_t tile;
        win_desc_t  win;
        logic       last;
    } tile_out_t;

endpackage

`default_nettype wire

// File: conv_tiling_ctrl.sv
`default_nettype none

module conv_tiling_ctrl
    import conv_tiling_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      start,
    input  wire conv_cfg_t cfg,
    input  wire logic      stall,
    input  wire logic      desc_valid,
    input  wire logic      desc_last,
    output conv_cfg_t      cfg_q,
    output logic           clear,
    output logic           gen_en,
    output logic           busy,
    output logic           done,
    output logic           cfg_err
);

    typedef enum logic {
        IDLE,
        RUN
    } state_t;

    state_t state;
    logic   cfg_ok;
    logic   last_acc;

    ////////////////////////////////////////////////////////////////////////////
    // configuration check
    ////////////////////////////////////////////////////////////////////////////

    // zero kernel or stride, pad not below kernel, empty output map
    always_comb begin
        cfg_ok = (cfg.k != '0) && (cfg.s != '0) && (cfg.p < cfg.k) &&
                 (cfg.ox != '0) && (cfg.oy != '0);
    end

    // final descriptor leaves the pipeline
    assign last_acc = desc_valid && desc_last && !stall;

    ////////////////////////////////////////////////////////////////////////////
    // run sequencing
    ////////////////////////////////////////////////////////////////////////////

    // counter stops by itself after its last tile,
    // run state only drains until the last acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            clear   <= 1'b0;
            done    <= 1'b0;
            cfg_err <= 1'b0;
        end else begin
            done    <= 1'b0;
            cfg_err <= 1'b0;
            // clear stays up until the counter sees an unstalled cycle
            if (!stall) begin
                clear <= 1'b0;
            end
            case (state)
                IDLE: begin
                    if (start) begin
                        if (cfg_ok) begin
                            state <= RUN;
                            clear <= 1'b1;
                        end else begin
                            cfg_err <= 1'b1;
                        end
                    end
                end
                RUN: begin
                    // start while busy falls through here unseen
                    if (last_acc) begin
                        state <= IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // layer config, only taken on a legal start
    always_ff @(posedge clk) begin
        if (state == IDLE && start && cfg_ok) begin
            cfg_q <= cfg;
        end
    end

    assign gen_en = (state == RUN);
    assign busy   = (state == RUN);

    // a run cannot both end and be rejected
    a_done_err_excl: assert property (@(posedge clk) disable iff (rst)
        !(done && cfg_err));

endmodule

`default_nettype wire

// File: tile_counter.sv
`default_nettype none

module tile_counter
    import conv_tiling_pkg::*;
#(
    parameter int TILE_X = 16,
    parameter int TILE_Y = 8
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire conv_cfg_t cfg_q,
    input  wire logic      clear,
    input  wire logic      gen_en,
    input  wire logic      stall,
    output tile_desc_t     tile_q,
    output logic           tile_valid,
    output logic           tile_last
);

    localparam logic [DIM_W-1:0] STEP_X = DIM_W'(TILE_X);
    localparam logic [DIM_W-1:0] STEP_Y = DIM_W'(TILE_Y);

    // origin of the next tile to emit
    logic [DIM_W-1:0] nx;
    logic [DIM_W-1:0] ny;
    // set once the final tile has gone out
    logic             stop;

    logic [DIM_W-1:0] sel_x;
    logic [DIM_W-1:0] sel_y;
    logic [DIM_W-1:0] rem_x;
    logic [DIM_W-1:0] rem_y;
    logic             edge_x;
    logic             edge_y;
    logic             emit;

    ////////////////////////////////////////////////////////////////////////////
    // origin select and edge clipping
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // new layer restarts at the map corner
        sel_x  = clear ? '0 : nx;
        sel_y  = clear ? '0 : ny;
        // outputs left to the map edge
        rem_x  = cfg_q.ox - sel_x;
        rem_y  = cfg_q.oy - sel_y;
        edge_x = (rem_x <= STEP_X);
        edge_y = (rem_y <= STEP_Y);
        emit   = gen_en && !stall && (clear || !stop);
    end

    // control side
    always_ff @(posedge clk) begin
        if (rst) begin
            tile_valid <= 1'b0;
            tile_last  <= 1'b0;
            nx         <= '0;
            ny         <= '0;
            stop       <= 1'b0;
        end else if (!stall) begin
            tile_valid <= emit;
            tile_last  <= emit && edge_x && edge_y;
            if (emit) begin
                // raster order, x inner
                if (edge_x) begin
                    nx <= '0;
                    ny <= sel_y + STEP_Y;
                end else begin
                    nx <= sel_x + STEP_X;
                    ny <= sel_y;
                end
                stop <= edge_x && edge_y;
            end
        end
    end

    // tile payload
    always_ff @(posedge clk) begin
        if (emit) begin
            tile_q.ox_start <= sel_x;
            tile_q.oy_start <= sel_y;
            tile_q.pox      <= edge_x ? rem_x : STEP_X;
            tile_q.poy      <= edge_y ? rem_y : STEP_Y;
        end
    end

    // emitted tile lies inside the map and is never empty
    a_tile_in_map: assert property (@(posedge clk) disable iff (rst)
        tile_valid |-> (tile_q.ox_start < cfg_q.ox) && (tile_q.pox != '0));

endmodule

`default_nettype wire

// File: input_window_calc.sv
`default_nettype none

module input_window_calc
    import conv_tiling_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire conv_cfg_t  cfg_q,
    input  wire tile_desc_t tile_q,
    input  wire logic       tile_valid,
    input  wire logic       tile_last,
    input  wire logic       stall,
    output tile_out_t       desc,
    output logic            desc_valid
);

    // headroom for origin times stride
    localparam int PW = DIM_W + KER_W + 1;

    // stage 1 registers
    tile_desc_t         s1_tile;
    logic               s1_last;
    logic               s1_valid;
    logic signed [DIM_W:0] s1_ix;
    logic signed [DIM_W:0] s1_iy;
    logic [DIM_W-1:0]   s1_iw;
    logic [DIM_W-1:0]   s1_ih;

    // stage 1 math
    logic signed [PW-1:0] org_x;
    logic signed [PW-1:0] org_y;
    logic [PW-1:0]        span_x;
    logic [PW-1:0]        span_y;

    // stage 2 math
    logic signed [PW-1:0] neg_x;
    logic signed [PW-1:0] neg_y;
    logic signed [PW-1:0] over_x;
    logic signed [PW-1:0] over_y;

    ////////////////////////////////////////////////////////////////////////////
    // stage 1: window origin and extent
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // origin = out origin * s - p, goes negative at the top/left edge
        org_x  = signed'(PW'(tile_q.ox_start) * PW'(cfg_q.s)) - signed'(PW'(cfg_q.p));
        org_y  = signed'(PW'(tile_q.oy_start) * PW'(cfg_q.s)) - signed'(PW'(cfg_q.p));
        // extent = (tile size - 1) * s + k
        span_x = (PW'(tile_q.pox) - PW'(1)) * PW'(cfg_q.s) + PW'(cfg_q.k);
        span_y = (PW'(tile_q.poy) - PW'(1)) * PW'(cfg_q.s) + PW'(cfg_q.k);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= tile_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_tile <= tile_q;
            s1_last <= tile_last;
            s1_ix   <= org_x[DIM_W:0];
            s1_iy   <= org_y[DIM_W:0];
            s1_iw   <= span_x[DIM_W-1:0];
            s1_ih   <= span_y[DIM_W-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2: padding on each side
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // part of the window left of / above the map
        neg_x  = (s1_ix < 0) ? -PW'(s1_ix) : '0;
        neg_y  = (s1_iy < 0) ? -PW'(s1_iy) : '0;
        // window end minus map size, clamped at zero
        over_x = PW'(s1_ix) + signed'(PW'(s1_iw)) - signed'(PW'(cfg_q.ix));
        over_y = PW'(s1_iy) + signed'(PW'(s1_ih)) - signed'(PW'(cfg_q.iy));
        if (over_x < 0) over_x = '0;
        if (over_y < 0) over_y = '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            desc_valid <= 1'b0;
        end else if (!stall) begin
            desc_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            desc.tile         <= s1_tile;
            desc.last         <= s1_last;
            desc.win.ix_start <= s1_ix;
            desc.win.iy_start <= s1_iy;
            desc.win.iw       <= s1_iw;
            desc.win.ih       <= s1_ih;
            desc.win.pad_l    <= neg_x[KER_W+3:0];
            desc.win.pad_t    <= neg_y[KER_W+3:0];
            desc.win.pad_r    <= over_x[KER_W+3:0];
            desc.win.pad_b    <= over_y[KER_W+3:0];
        end
    end

    // window always covers at least one kernel
    a_win_covers_k: assert property (@(posedge clk) disable iff (rst)
        desc_valid |-> (desc.win.iw >= DIM_W'(cfg_q.k)));

endmodule

`default_nettype wire

// File: conv_tiling.sv
`default_nettype none

module conv_tiling
    import conv_tiling_pkg::*;
#(
    parameter int TILE_X = 16,
    parameter int TILE_Y = 8
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      start,
    input  wire conv_cfg_t cfg,
    input  wire logic      stall,
    output tile_out_t      desc,
    output logic           desc_valid,
    output logic           busy,
    output logic           done,
    output logic           cfg_err
);

    ////////////////////////////////////////////////////////////////////////////
    // internal links
    ////////////////////////////////////////////////////////////////////////////

    conv_cfg_t  cfg_q;
    logic       clear;
    logic       gen_en;
    tile_desc_t tile_q;
    logic       tile_valid;
    logic       tile_last;

    // start check, run state, done
    conv_tiling_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .cfg        (cfg),
        .stall      (stall),
        .desc_valid (desc_valid),
        .desc_last  (desc.last),
        .cfg_q      (cfg_q),
        .clear      (clear),
        .gen_en     (gen_en),
        .busy       (busy),
        .done       (done),
        .cfg_err    (cfg_err)
    );

    // raster tile origins, 1 stage
    tile_counter #(
        .TILE_X (TILE_X),
        .TILE_Y (TILE_Y)
    ) i_tile_counter (
        .clk        (clk),
        .rst        (rst),
        .cfg_q      (cfg_q),
        .clear      (clear),
        .gen_en     (gen_en),
        .stall      (stall),
        .tile_q     (tile_q),
        .tile_valid (tile_valid),
        .tile_last  (tile_last)
    );

    // input window and padding, 2 stages
    input_window_calc i_input_window_calc (
        .clk        (clk),
        .rst        (rst),
        .cfg_q      (cfg_q),
        .tile_q     (tile_q),
        .tile_valid (tile_valid),
        .tile_last  (tile_last),
        .stall      (stall),
        .desc       (desc),
        .desc_valid (desc_valid)
    );

endmodule

`default_nettype wire

// File: conv_tiling_tb.sv
`default_nettype none

module conv_tiling_tb
    import conv_tiling_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // must match the DUT defaults
    localparam int TILE_X = 16;
    localparam int TILE_Y = 8;
    localparam int N_TESTS = 7;
    // layer per test with stall and start-while-busy enables
    localparam int TEST_CFG[N_TESTS]   = '{0, 1, 2, 3, 2, 1, 3};
    localparam bit TEST_STALL[N_TESTS] = '{0, 0, 0, 0, 1, 1, 0};
    localparam bit TEST_POKE[N_TESTS]  = '{0, 0, 0, 0, 0, 0, 1};

    logic      clk;
    logic      rst;
    logic      start;
    conv_cfg_t cfg;
    logic      stall;
    tile_out_t desc;
    logic      desc_valid;
    logic      busy;
    logic      done;
    logic      cfg_err;

    // shared between the test tasks and the checker
    conv_cfg_t   cur_cfg;
    int          cur_total;
    int          acc_idx;
    int          done_cnt;
    int          err_pulses;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    bit          stall_en;
    bit          expect_done;
    bit          hold_prev;
    tile_out_t   prev_desc;
    logic [31:0] rng = 32'h98d9;

    conv_tiling i_conv_tiling (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .cfg        (cfg),
        .stall      (stall),
        .desc       (desc),
        .desc_valid (desc_valid),
        .busy       (busy),
        .done       (done),
        .cfg_err    (cfg_err)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int clamp0(int v);
        return (v < 0) ? 0 : v;
    endfunction

    function automatic conv_cfg_t get_cfg(int idx);
        conv_cfg_t c;
        case (idx)
            0: c = '{ix: 16'd128, iy: 16'd128, ox: 16'd64, oy: 16'd64, k: 4'd1, s: 4'd1, p: 4'd0};
            1: c = '{ix: 16'd32, iy: 16'd32, ox: 16'd32, oy: 16'd32, k: 4'd3, s: 4'd1, p: 4'd1};
            2: c = '{ix: 16'd64, iy: 16'd16, ox: 16'd32, oy: 16'd8, k: 4'd3, s: 4'd2, p: 4'd1};
            3: c = '{ix: 16'd40, iy: 16'd20, ox: 16'd20, oy: 16'd10, k: 4'd6, s: 4'd2, p: 4'd2};
            // pad equal to kernel is illegal
            default: c = '{ix: 16'd32, iy: 16'd32, ox: 16'd16, oy: 16'd16, k: 4'd3, s: 4'd1,
                           p: 4'd3};
        endcase
        return c;
    endfunction

    function automatic int n_tiles(conv_cfg_t c);
        return ((int'(c.ox) + TILE_X - 1) / TILE_X) * ((int'(c.oy) + TILE_Y - 1) / TILE_Y);
    endfunction

    // expected descriptor n of a layer in raster order with x inner
    function automatic tile_out_t ref_desc(conv_cfg_t c, int n);
        tile_out_t r;
        int tiles_x;
        int ox0;
        int oy0;
        int pox;
        int poy;
        int x0;
        int y0;
        int w;
        int h;
        tiles_x = (int'(c.ox) + TILE_X - 1) / TILE_X;
        ox0 = (n % tiles_x) * TILE_X;
        oy0 = (n / tiles_x) * TILE_Y;
        // clip at the right and bottom map edge
        pox = (int'(c.ox) - ox0 < TILE_X) ? int'(c.ox) - ox0 : TILE_X;
        poy = (int'(c.oy) - oy0 < TILE_Y) ? int'(c.oy) - oy0 : TILE_Y;
        x0  = ox0 * int'(c.s) - int'(c.p);
        y0  = oy0 * int'(c.s) - int'(c.p);
        w   = (pox - 1) * int'(c.s) + int'(c.k);
        h   = (poy - 1) * int'(c.s) + int'(c.k);
        r.tile.ox_start = DIM_W'(ox0);
        r.tile.oy_start = DIM_W'(oy0);
        r.tile.pox      = DIM_W'(pox);
        r.tile.poy      = DIM_W'(poy);
        r.win.ix_start  = (DIM_W+1)'(x0);
        r.win.iy_start  = (DIM_W+1)'(y0);
        r.win.iw        = DIM_W'(w);
        r.win.ih        = DIM_W'(h);
        r.win.pad_l     = (KER_W+4)'(clamp0(-x0));
        r.win.pad_t     = (KER_W+4)'(clamp0(-y0));
        r.win.pad_r     = (KER_W+4)'(clamp0(x0 + w - int'(c.ix)));
        r.win.pad_b     = (KER_W+4)'(clamp0(y0 + h - int'(c.iy)));
        r.last          = (n == n_tiles(c) - 1);
        return r;
    endfunction

    task automatic report_error(string what);
        $display("Error t=%0t %s", $time, what);
        err_cnt++;
    endtask

    task automatic cmp_field(string name, int expv, int actv);
        if (expv != actv) begin
            $display("Fail t=%0t desc.%s exp %0d got %0d", $time, name, expv, actv);
            err_cnt++;
        end
    endtask

    task automatic check_desc(tile_out_t e);
        cmp_field("tile.ox_start", int'(e.tile.ox_start), int'(desc.tile.ox_start));
        cmp_field("tile.oy_start", int'(e.tile.oy_start), int'(desc.tile.oy_start));
        cmp_field("tile.pox", int'(e.tile.pox), int'(desc.tile.pox));
        cmp_field("tile.poy", int'(e.tile.poy), int'(desc.tile.poy));
        cmp_field("win.ix_start", int'($signed(e.win.ix_start)), int'($signed(desc.win.ix_start)));
        cmp_field("win.iy_start", int'($signed(e.win.iy_start)), int'($signed(desc.win.iy_start)));
        cmp_field("win.iw", int'(e.win.iw), int'(desc.win.iw));
        cmp_field("win.ih", int'(e.win.ih), int'(desc.win.ih));
        cmp_field("win.pad_l", int'(e.win.pad_l), int'(desc.win.pad_l));
        cmp_field("win.pad_r", int'(e.win.pad_r), int'(desc.win.pad_r));
        cmp_field("win.pad_t", int'(e.win.pad_t), int'(desc.win.pad_t));
        cmp_field("win.pad_b", int'(e.win.pad_b), int'(desc.win.pad_b));
        cmp_field("last", int'(e.last), int'(desc.last));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // clock, stall source, checker, watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // roughly 3 in 8 cycles stalled when enabled
    initial begin
        forever begin
            @(posedge clk);
            if (stall_en) begin
                rng = xorshift(rng);
                stall <= (rng[2:0] < 3'd3);
            end else begin
                stall <= 1'b0;
            end
        end
    end

    // outputs read at the rising edge still hold their pre-edge values
    initial begin
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (hold_prev) begin
                    if (!desc_valid) begin
                        report_error("desc_valid dropped while stalled");
                    end
                    if (desc != prev_desc) begin
                        $display("Fail t=%0t desc exp %h got %h", $time, prev_desc, desc);
                        err_cnt++;
                    end
                end
                if (expect_done && !done) begin
                    report_error("no done pulse after the last descriptor");
                end
                if (done && !expect_done) begin
                    report_error("done pulsed without a final acceptance");
                end
                if (done) begin
                    done_cnt++;
                    if (busy) begin
                        report_error("busy still high with done");
                    end
                end
                expect_done = 1'b0;
                if (cfg_err) begin
                    err_pulses++;
                end
                if (desc_valid && !stall) begin
                    if (acc_idx >= cur_total) begin
                        report_error("descriptor accepted beyond the end of the layer");
                    end else begin
                        check_desc(ref_desc(cur_cfg, acc_idx));
                        expect_done = (acc_idx == cur_total - 1);
                    end
                    acc_idx++;
                end
                hold_prev = desc_valid && stall;
                prev_desc = desc;
            end
        end
    end

    // 8 cycles per tile over all runs plus room for reset and test gaps
    initial begin
        int limit;
        limit = 300;
        for (int i = 0; i < N_TESTS; i++) begin
            limit += 8 * n_tiles(get_cfg(TEST_CFG[i]));
        end
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Finished with errors");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_layer(int num, int idx, bit use_stall, bit poke);
        int errs0;
        int lat;
        errs0      = err_cnt;
        cur_cfg    = get_cfg(idx);
        cur_total  = n_tiles(cur_cfg);
        acc_idx    = 0;
        done_cnt   = 0;
        err_pulses = 0;
        stall_en   <= use_stall;
        @(posedge clk);
        start <= 1'b1;
        cfg   <= cur_cfg;
        @(posedge clk);
        start <= 1'b0;
        if (!use_stall) begin
            lat = 0;
            do begin
                @(posedge clk);
                lat++;
            end while (!desc_valid && lat < 20);
            // rises on the 3rd edge after start is taken and shows on the 4th
            if (lat != 4) begin
                $display("Fail t=%0t first desc_valid latency exp 4 got %0d", $time, lat);
                err_cnt++;
            end
            if (poke) begin
                if (!busy) begin
                    report_error("busy low in the middle of a layer");
                end
                // a different layer that must be ignored
                start <= 1'b1;
                cfg   <= get_cfg(0);
                @(posedge clk);
                start <= 1'b0;
            end
        end
        wait (done_cnt == 1);
        stall_en <= 1'b0;
        repeat (3) @(posedge clk);
        if (acc_idx != cur_total) begin
            $display("Fail t=%0t accepted tiles exp %0d got %0d", $time, cur_total, acc_idx);
            err_cnt++;
        end
        if (done_cnt != 1) begin
            $display("Fail t=%0t done pulses exp 1 got %0d", $time, done_cnt);
            err_cnt++;
        end
        if (busy || err_pulses != 0) begin
            report_error("busy or cfg_err set after the layer");
        end
        if (err_cnt == errs0) begin
            pass_cnt++;
            $display("test %0d cfg %0d stall %0d poke %0d: pass, %0d tiles", num, idx,
                     use_stall, poke, cur_total);
        end else begin
            fail_cnt++;
            $display("test %0d cfg %0d stall %0d poke %0d: FAIL, %0d errors", num, idx,
                     use_stall, poke, err_cnt - errs0);
        end
    endtask

    task automatic bad_layer(int num);
        int errs0;
        errs0      = err_cnt;
        cur_cfg    = get_cfg(4);
        cur_total  = 0;
        acc_idx    = 0;
        done_cnt   = 0;
        err_pulses = 0;
        @(posedge clk);
        start <= 1'b1;
        cfg   <= cur_cfg;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 1; i <= 8; i++) begin
            @(posedge clk);
            if (i == 1 && !cfg_err) begin
                report_error("no cfg_err pulse one cycle after an illegal start");
            end
            if (busy || desc_valid) begin
                report_error("illegal configuration started a run");
            end
        end
        if (err_pulses != 1) begin
            $display("Fail t=%0t cfg_err pulses exp 1 got %0d", $time, err_pulses);
            err_cnt++;
        end
        if (err_cnt == errs0) begin
            pass_cnt++;
            $display("test %0d illegal cfg: pass", num);
        end else begin
            fail_cnt++;
            $display("test %0d illegal cfg: FAIL, %0d errors", num, err_cnt - errs0);
        end
    endtask

    initial begin
        rst      = 1'b1;
        start    = 1'b0;
        cfg      = '0;
        stall    = 1'b0;
        stall_en = 1'b0;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < N_TESTS; i++) begin
            run_layer(i + 1, TEST_CFG[i], TEST_STALL[i], TEST_POKE[i]);
        end
        bad_layer(N_TESTS + 1);
        $display("tests passed %0d failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: conv_tiling.f
conv_tiling_pkg.sv
conv_tiling_ctrl.sv
tile_counter.sv
input_window_calc.sv
conv_tiling.sv
conv_tiling_tb.sv

// File: Makefile
# Verilator flow for the convolution tiling sequencer

VERILATOR  ?= verilator
TOP        := conv_tiling_tb
FILELIST   := conv_tiling.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Finished with no errors

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

# the log decides pass or fail, not the exit code of the binary
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
